// File: common/decodePkg.sv
package decodePkg;

	// major opcodes
	localparam logic [5:0]
		opRType = 6'b000000, opRegImm = 6'b000001, opJ = 6'b000010,
		opJal = 6'b000011, opBeq = 6'b000100, opBne = 6'b000101,
		opBlez = 6'b000110, opBgtz = 6'b000111;
	localparam logic [5:0]
		opAddi = 6'b001000, opAddiu = 6'b001001, opSlti = 6'b001010,
		opSltiu = 6'b001011, opAndi = 6'b001100, opOri = 6'b001101,
		opXori = 6'b001110, opLui = 6'b001111;
	localparam logic [5:0]
		opCop0 = 6'b010000, opSpecial2 = 6'b011100;
	localparam logic [5:0]
		opLb = 6'b100000, opLh = 6'b100001, opLwl = 6'b100010,
		opLw = 6'b100011, opLbu = 6'b100100, opLhu = 6'b100101,
		opLwr = 6'b100110, opLl = 6'b110000;
	localparam logic [5:0]
		opSb = 6'b101000, opSh = 6'b101001, opSwl = 6'b101010,
		opSw = 6'b101011, opSwr = 6'b101110;

	// special functs
	localparam logic [5:0]
		fnSll = 6'b000000, fnSrl = 6'b000010, fnSra = 6'b000011,
		fnSllv = 6'b000100, fnSrlv = 6'b000110, fnSrav = 6'b000111;
	localparam logic [5:0]
		fnJr = 6'b001000, fnJalr = 6'b001001, fnMovz = 6'b001010,
		fnMovn = 6'b001011, fnSyscall = 6'b001100, fnBreak = 6'b001101;
	localparam logic [5:0]
		fnMfhi = 6'b010000, fnMthi = 6'b010001, fnMflo = 6'b010010,
		fnMtlo = 6'b010011;
	localparam logic [5:0]
		fnMult = 6'b011000, fnMultu = 6'b011001, fnDiv = 6'b011010,
		fnDivu = 6'b011011;
	localparam logic [5:0]
		fnAdd = 6'b100000, fnAddu = 6'b100001, fnSub = 6'b100010,
		fnSubu = 6'b100011, fnAnd = 6'b100100, fnOr = 6'b100101,
		fnXor = 6'b100110, fnNor = 6'b100111, fnSlt = 6'b101010,
		fnSltu = 6'b101011;

	// special2 functs
	localparam logic [5:0]
		fnMadd = 6'b000000, fnMaddu = 6'b000001, fnMul = 6'b000010,
		fnMsub = 6'b000100, fnMsubu = 6'b000101, fnClz = 6'b100000,
		fnClo = 6'b100001;

	// only valid under cop0 with the co selector
	localparam logic [5:0] fnEret = 6'b011000;

	localparam logic [4:0]
		rtBltz = 5'b00000, rtBgez = 5'b00001,
		rtBltzal = 5'b10000, rtBgezal = 5'b10001;
	localparam logic [4:0]
		rsMfc0 = 5'b00000, rsMtc0 = 5'b00100, rsCo = 5'b10000;

	localparam logic [4:0] linkReg = 5'd31;

	typedef enum logic [5:0] {
		aluRType, aluRotr, aluRotrv, aluAddi, aluAddiu, aluSlti,
		aluSltiu, aluAndi, aluOri, aluXori, aluLui, aluMem,
		aluMtc0, aluMfc0, aluClo, aluClz, aluMul, aluMadd,
		aluMaddu, aluMsub, aluMsubu,
		aluUseless = 6'h3f
	} aluOpT;

	typedef enum logic [2:0] {
		brNone, brEq, brNe, brLez, brGtz, brLtz, brGez
	} branchCondT;

	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} instrFieldsT;

	typedef struct packed {
		logic regWrite;
		logic [4:0] writeReg;
		logic isImm;
		logic signExt;
	} regCtrlT;

	typedef struct packed {
		logic memRead;
		logic memWrite;
	} memCtrlT;

	typedef struct packed {
		aluOpT aluOp;
		logic mulDivEn;
		logic mfhi;
		logic mflo;
	} aluCtrlT;

	typedef struct packed {
		logic cp0Write;
		logic isMfc;
		logic eret;
	} privCtrlT;

endpackage

// File: mainDecoder/aluOpDecode.sv
`timescale 1ns/100ps

module aluOpDecode (
	input decodePkg::instrFieldsT instr,
	output decodePkg::aluCtrlT aluCtrl,
	output logic reservedInstr
);

	decodePkg::aluOpT aluOp;
	logic mulDivEn;
	logic isRType;
	logic isSpecial2;

	assign isRType = instr.op == decodePkg::opRType;
	assign isSpecial2 = instr.op == decodePkg::opSpecial2;

	always_comb begin
		mulDivEn = 1'b0;
		if (isRType) begin
			case (instr.funct)
				decodePkg::fnMult, decodePkg::fnMultu,
				decodePkg::fnDiv, decodePkg::fnDivu: mulDivEn = 1'b1;
				default: mulDivEn = 1'b0;
			endcase
		end else if (isSpecial2) begin
			case (instr.funct)
				decodePkg::fnMul, decodePkg::fnMadd, decodePkg::fnMaddu,
				decodePkg::fnMsub, decodePkg::fnMsubu: mulDivEn = 1'b1;
				default: mulDivEn = 1'b0;
			endcase
		end
	end

	always_comb begin
		aluOp = decodePkg::aluUseless;
		reservedInstr = 1'b0;
		case (instr.op)
			decodePkg::opRType: begin
				case (instr.funct)
					decodePkg::fnSll, decodePkg::fnSra, decodePkg::fnSllv, decodePkg::fnSrav,
					decodePkg::fnJr, decodePkg::fnJalr, decodePkg::fnMovz, decodePkg::fnMovn,
					decodePkg::fnSyscall, decodePkg::fnBreak,
					decodePkg::fnMfhi, decodePkg::fnMthi, decodePkg::fnMflo, decodePkg::fnMtlo,
					decodePkg::fnMult, decodePkg::fnMultu, decodePkg::fnDiv, decodePkg::fnDivu,
					decodePkg::fnAdd, decodePkg::fnAddu, decodePkg::fnSub, decodePkg::fnSubu,
					decodePkg::fnAnd, decodePkg::fnOr, decodePkg::fnXor, decodePkg::fnNor,
					decodePkg::fnSlt, decodePkg::fnSltu: aluOp = decodePkg::aluRType;
					// bit 21 turns srl into rotr
					decodePkg::fnSrl:
						aluOp = instr.rs[0] ? decodePkg::aluRotr : decodePkg::aluRType;
					// bit 6 turns srlv into rotrv
					decodePkg::fnSrlv:
						aluOp = instr.shamt[0] ? decodePkg::aluRotrv : decodePkg::aluRType;
					default: reservedInstr = 1'b1;
				endcase
			end
			decodePkg::opRegImm: begin
				case (instr.rt)
					decodePkg::rtBltz, decodePkg::rtBgez,
					decodePkg::rtBltzal, decodePkg::rtBgezal: reservedInstr = 1'b0;
					default: reservedInstr = 1'b1;
				endcase
			end
			// jumps and branches leave the alu idle
			decodePkg::opJ, decodePkg::opJal, decodePkg::opBeq, decodePkg::opBne,
			decodePkg::opBlez, decodePkg::opBgtz: reservedInstr = 1'b0;
			decodePkg::opAddi: aluOp = decodePkg::aluAddi;
			decodePkg::opAddiu: aluOp = decodePkg::aluAddiu;
			decodePkg::opSlti: aluOp = decodePkg::aluSlti;
			decodePkg::opSltiu: aluOp = decodePkg::aluSltiu;
			decodePkg::opAndi: aluOp = decodePkg::aluAndi;
			decodePkg::opOri: aluOp = decodePkg::aluOri;
			decodePkg::opXori: aluOp = decodePkg::aluXori;
			decodePkg::opLui: aluOp = decodePkg::aluLui;
			decodePkg::opLb, decodePkg::opLbu, decodePkg::opLh, decodePkg::opLhu,
			decodePkg::opLw, decodePkg::opLwl, decodePkg::opLwr, decodePkg::opLl,
			decodePkg::opSb, decodePkg::opSh, decodePkg::opSw,
			decodePkg::opSwl, decodePkg::opSwr: aluOp = decodePkg::aluMem;
			decodePkg::opCop0: begin
				case (instr.rs)
					decodePkg::rsMfc0: aluOp = decodePkg::aluMfc0;
					decodePkg::rsMtc0: aluOp = decodePkg::aluMtc0;
					// eret is the only co function left
					decodePkg::rsCo: reservedInstr = instr.funct != decodePkg::fnEret;
					default: reservedInstr = 1'b1;
				endcase
			end
			decodePkg::opSpecial2: begin
				case (instr.funct)
					decodePkg::fnMul: aluOp = decodePkg::aluMul;
					decodePkg::fnMadd: aluOp = decodePkg::aluMadd;
					decodePkg::fnMaddu: aluOp = decodePkg::aluMaddu;
					decodePkg::fnMsub: aluOp = decodePkg::aluMsub;
					decodePkg::fnMsubu: aluOp = decodePkg::aluMsubu;
					decodePkg::fnClo: aluOp = decodePkg::aluClo;
					decodePkg::fnClz: aluOp = decodePkg::aluClz;
					default: reservedInstr = 1'b1;
				endcase
			end
			default: reservedInstr = 1'b1;
		endcase
	end

	assign aluCtrl = '{
		aluOp: aluOp,
		mulDivEn: mulDivEn,
		mfhi: isRType && instr.funct == decodePkg::fnMfhi,
		mflo: isRType && instr.funct == decodePkg::fnMflo
	};

endmodule

// File: mainDecoder/regWriteDecode.sv
`timescale 1ns/100ps

module regWriteDecode (
	input decodePkg::instrFieldsT instr,
	output decodePkg::regCtrlT regCtrl,
	output decodePkg::memCtrlT memCtrl
);

	typedef enum logic [2:0] {
		clsNone, clsRd, clsRt, clsLink, clsImm, clsLoad, clsStore
	} writeClassT;

	writeClassT writeClass;

	always_comb begin
		writeClass = clsNone;
		case (instr.op)
			decodePkg::opRType: begin
				case (instr.funct)
					decodePkg::fnJalr: writeClass = clsLink;
					decodePkg::fnJr, decodePkg::fnMult, decodePkg::fnMultu,
					decodePkg::fnDiv, decodePkg::fnDivu, decodePkg::fnMthi,
					decodePkg::fnMtlo, decodePkg::fnSyscall,
					decodePkg::fnBreak: writeClass = clsNone;
					// reserved r-type encodings also land here
					default: writeClass = clsRd;
				endcase
			end
			decodePkg::opRegImm:
				if (instr.rt == decodePkg::rtBltzal || instr.rt == decodePkg::rtBgezal)
					writeClass = clsLink;
			decodePkg::opJal: writeClass = clsLink;
			decodePkg::opAddi, decodePkg::opAddiu, decodePkg::opSlti, decodePkg::opSltiu,
			decodePkg::opAndi, decodePkg::opOri, decodePkg::opXori,
			decodePkg::opLui: writeClass = clsImm;
			decodePkg::opLb, decodePkg::opLbu, decodePkg::opLh, decodePkg::opLhu,
			decodePkg::opLw, decodePkg::opLwl, decodePkg::opLwr,
			decodePkg::opLl: writeClass = clsLoad;
			decodePkg::opSb, decodePkg::opSh, decodePkg::opSw,
			decodePkg::opSwl, decodePkg::opSwr: writeClass = clsStore;
			decodePkg::opCop0:
				if (instr.rs == decodePkg::rsMfc0)
					writeClass = clsRt;
			decodePkg::opSpecial2: begin
				case (instr.funct)
					decodePkg::fnMul, decodePkg::fnClo, decodePkg::fnClz: writeClass = clsRd;
					default: writeClass = clsNone;
				endcase
			end
			default: writeClass = clsNone;
		endcase
	end

	always_comb begin
		// andi, ori, xori and lui zero-extend
		regCtrl = '{
			regWrite: 1'b0,
			writeReg: instr.rd,
			isImm: 1'b0,
			signExt: |(instr.op[5:2] ^ 4'b0011)
		};
		memCtrl = '{memRead: 1'b0, memWrite: 1'b0};
		case (writeClass)
			clsRd: regCtrl.regWrite = 1'b1;
			clsRt: begin
				regCtrl.regWrite = 1'b1;
				regCtrl.writeReg = instr.rt;
			end
			clsLink: begin
				regCtrl.regWrite = 1'b1;
				regCtrl.writeReg = decodePkg::linkReg;
			end
			clsImm, clsLoad: begin
				regCtrl.regWrite = 1'b1;
				regCtrl.writeReg = instr.rt;
				regCtrl.isImm = 1'b1;
				memCtrl.memRead = writeClass == clsLoad;
			end
			clsStore: begin
				regCtrl.isImm = 1'b1;
				memCtrl.memWrite = 1'b1;
			end
			default: regCtrl.regWrite = 1'b0;
		endcase
	end

endmodule

// File: mainDecoder/branchDecode.sv
`timescale 1ns/100ps

module branchDecode (
	input decodePkg::instrFieldsT instr,
	output decodePkg::branchCondT branchCond
);

	always_comb begin
		case (instr.op)
			decodePkg::opBeq: branchCond = decodePkg::brEq;
			decodePkg::opBne: branchCond = decodePkg::brNe;
			decodePkg::opBlez: branchCond = decodePkg::brLez;
			decodePkg::opBgtz: branchCond = decodePkg::brGtz;
			decodePkg::opRegImm: begin
				// link variants share the compare with their plain forms
				case (instr.rt)
					decodePkg::rtBltz, decodePkg::rtBltzal:
						branchCond = decodePkg::brLtz;
					decodePkg::rtBgez, decodePkg::rtBgezal:
						branchCond = decodePkg::brGez;
					// unknown selector falls back to ltz
					default: branchCond = decodePkg::brLtz;
				endcase
			end
			default: branchCond = decodePkg::brNone;
		endcase
	end

endmodule

// File: mainDecoder/privDecode.sv
`timescale 1ns/100ps

module privDecode (
	input decodePkg::instrFieldsT instr,
	output decodePkg::privCtrlT privCtrl
);

	logic isCop0;
	logic isCo;

	assign isCop0 = instr.op == decodePkg::opCop0;
	assign isCo = isCop0 && instr.rs == decodePkg::rsCo;

	// mfc0 reads cp0 into rt, mtc0 writes rt into cp0
	assign privCtrl = '{
		cp0Write: isCop0 && instr.rs == decodePkg::rsMtc0,
		isMfc: isCop0 && instr.rs == decodePkg::rsMfc0,
		eret: isCo && instr.funct == decodePkg::fnEret
	};

endmodule

// File: mainDecoder/mainDecoder.sv
`timescale 1ns/100ps

module mainDecoder (
	input decodePkg::instrFieldsT instr,
	output decodePkg::regCtrlT regCtrl,
	output decodePkg::memCtrlT memCtrl,
	output decodePkg::aluCtrlT aluCtrl,
	output decodePkg::branchCondT branchCond,
	output decodePkg::privCtrlT privCtrl,
	output logic reservedInstr
);

	// legality is judged by the alu decoder alone
	aluOpDecode aluOpDecodeInst (
		.instr(instr),
		.aluCtrl(aluCtrl),
		.reservedInstr(reservedInstr)
	);

	regWriteDecode regWriteDecodeInst (
		.instr(instr),
		.regCtrl(regCtrl),
		.memCtrl(memCtrl)
	);

	branchDecode branchDecodeInst (
		.instr(instr),
		.branchCond(branchCond)
	);

	privDecode privDecodeInst (
		.instr(instr),
		.privCtrl(privCtrl)
	);

endmodule

// File: test/refDecode.svh
`ifndef REF_DECODE_SVH
`define REF_DECODE_SVH

typedef struct packed {
	decodePkg::regCtrlT regCtrl;
	decodePkg::memCtrlT memCtrl;
	decodePkg::aluCtrlT aluCtrl;
	decodePkg::branchCondT branchCond;
	decodePkg::privCtrlT privCtrl;
	logic reservedInstr;
} expectT;

// expected control fields, built group by group from the decode table
function automatic expectT refDecode(input decodePkg::instrFieldsT i);
	expectT e;
	e = '0;
	e.regCtrl.writeReg = i.rd;
	e.regCtrl.signExt = i.op[5:2] != 4'b0011;
	e.aluCtrl.aluOp = decodePkg::aluUseless;
	e.branchCond = decodePkg::brNone;
	case (i.op)
		decodePkg::opRType: begin
			e.aluCtrl.aluOp = decodePkg::aluRType;
			e.aluCtrl.mfhi = i.funct == decodePkg::fnMfhi;
			e.aluCtrl.mflo = i.funct == decodePkg::fnMflo;
			// rd is written unless the funct says otherwise
			e.regCtrl.regWrite = 1'b1;
			case (i.funct)
				decodePkg::fnJr, decodePkg::fnSyscall, decodePkg::fnBreak,
				decodePkg::fnMthi, decodePkg::fnMtlo: e.regCtrl.regWrite = 1'b0;
				decodePkg::fnMult, decodePkg::fnMultu, decodePkg::fnDiv,
				decodePkg::fnDivu: begin
					e.regCtrl.regWrite = 1'b0;
					e.aluCtrl.mulDivEn = 1'b1;
				end
				decodePkg::fnJalr: e.regCtrl.writeReg = decodePkg::linkReg;
				decodePkg::fnSrl: if (i.rs[0]) e.aluCtrl.aluOp = decodePkg::aluRotr;
				decodePkg::fnSrlv: if (i.shamt[0]) e.aluCtrl.aluOp = decodePkg::aluRotrv;
				decodePkg::fnSll, decodePkg::fnSra, decodePkg::fnSllv, decodePkg::fnSrav,
				decodePkg::fnMovz, decodePkg::fnMovn, decodePkg::fnMfhi, decodePkg::fnMflo,
				decodePkg::fnAdd, decodePkg::fnAddu, decodePkg::fnSub, decodePkg::fnSubu,
				decodePkg::fnAnd, decodePkg::fnOr, decodePkg::fnXor, decodePkg::fnNor,
				decodePkg::fnSlt, decodePkg::fnSltu: e.regCtrl.regWrite = 1'b1;
				default: begin
					e.reservedInstr = 1'b1;
					e.aluCtrl.aluOp = decodePkg::aluUseless;
				end
			endcase
		end
		decodePkg::opRegImm: begin
			case (i.rt)
				decodePkg::rtBltz: e.branchCond = decodePkg::brLtz;
				decodePkg::rtBgez: e.branchCond = decodePkg::brGez;
				decodePkg::rtBltzal, decodePkg::rtBgezal: begin
					e.regCtrl.regWrite = 1'b1;
					e.regCtrl.writeReg = decodePkg::linkReg;
					e.branchCond = i.rt[0] ? decodePkg::brGez : decodePkg::brLtz;
				end
				// unknown selectors still compare like bltz
				default: begin
					e.reservedInstr = 1'b1;
					e.branchCond = decodePkg::brLtz;
				end
			endcase
		end
		decodePkg::opJ: e.reservedInstr = 1'b0;
		decodePkg::opJal: begin
			e.regCtrl.regWrite = 1'b1;
			e.regCtrl.writeReg = decodePkg::linkReg;
		end
		decodePkg::opBeq: e.branchCond = decodePkg::brEq;
		decodePkg::opBne: e.branchCond = decodePkg::brNe;
		decodePkg::opBlez: e.branchCond = decodePkg::brLez;
		decodePkg::opBgtz: e.branchCond = decodePkg::brGtz;
		decodePkg::opAddi, decodePkg::opAddiu, decodePkg::opSlti, decodePkg::opSltiu,
		decodePkg::opAndi, decodePkg::opOri, decodePkg::opXori, decodePkg::opLui: begin
			e.regCtrl.regWrite = 1'b1;
			e.regCtrl.writeReg = i.rt;
			e.regCtrl.isImm = 1'b1;
			case (i.op)
				decodePkg::opAddi: e.aluCtrl.aluOp = decodePkg::aluAddi;
				decodePkg::opAddiu: e.aluCtrl.aluOp = decodePkg::aluAddiu;
				decodePkg::opSlti: e.aluCtrl.aluOp = decodePkg::aluSlti;
				decodePkg::opSltiu: e.aluCtrl.aluOp = decodePkg::aluSltiu;
				decodePkg::opAndi: e.aluCtrl.aluOp = decodePkg::aluAndi;
				decodePkg::opOri: e.aluCtrl.aluOp = decodePkg::aluOri;
				decodePkg::opXori: e.aluCtrl.aluOp = decodePkg::aluXori;
				default: e.aluCtrl.aluOp = decodePkg::aluLui;
			endcase
		end
		decodePkg::opLb, decodePkg::opLbu, decodePkg::opLh, decodePkg::opLhu,
		decodePkg::opLw, decodePkg::opLwl, decodePkg::opLwr, decodePkg::opLl: begin
			e.regCtrl.regWrite = 1'b1;
			e.regCtrl.writeReg = i.rt;
			e.regCtrl.isImm = 1'b1;
			e.memCtrl.memRead = 1'b1;
			e.aluCtrl.aluOp = decodePkg::aluMem;
		end
		decodePkg::opSb, decodePkg::opSh, decodePkg::opSw,
		decodePkg::opSwl, decodePkg::opSwr: begin
			e.regCtrl.isImm = 1'b1;
			e.memCtrl.memWrite = 1'b1;
			e.aluCtrl.aluOp = decodePkg::aluMem;
		end
		decodePkg::opCop0: begin
			case (i.rs)
				decodePkg::rsMfc0: begin
					e.aluCtrl.aluOp = decodePkg::aluMfc0;
					e.privCtrl.isMfc = 1'b1;
					e.regCtrl.regWrite = 1'b1;
					e.regCtrl.writeReg = i.rt;
				end
				decodePkg::rsMtc0: begin
					e.aluCtrl.aluOp = decodePkg::aluMtc0;
					e.privCtrl.cp0Write = 1'b1;
				end
				decodePkg::rsCo: begin
					e.privCtrl.eret = i.funct == decodePkg::fnEret;
					e.reservedInstr = !e.privCtrl.eret;
				end
				default: e.reservedInstr = 1'b1;
			endcase
		end
		decodePkg::opSpecial2: begin
			case (i.funct)
				decodePkg::fnMul: e.aluCtrl.aluOp = decodePkg::aluMul;
				decodePkg::fnMadd: e.aluCtrl.aluOp = decodePkg::aluMadd;
				decodePkg::fnMaddu: e.aluCtrl.aluOp = decodePkg::aluMaddu;
				decodePkg::fnMsub: e.aluCtrl.aluOp = decodePkg::aluMsub;
				decodePkg::fnMsubu: e.aluCtrl.aluOp = decodePkg::aluMsubu;
				decodePkg::fnClo: e.aluCtrl.aluOp = decodePkg::aluClo;
				decodePkg::fnClz: e.aluCtrl.aluOp = decodePkg::aluClz;
				default: e.reservedInstr = 1'b1;
			endcase
			// legal functs with bit 5 clear are the multiply family
			e.aluCtrl.mulDivEn = !e.reservedInstr && !i.funct[5];
			e.regCtrl.regWrite = i.funct == decodePkg::fnMul || i.funct == decodePkg::fnClo
				|| i.funct == decodePkg::fnClz;
		end
		default: e.reservedInstr = 1'b1;
	endcase
	return e;
endfunction

task automatic checkRegCtrl(input decodePkg::regCtrlT act, input decodePkg::regCtrlT exp);
	if (act !== exp) begin
		$display("ERROR t=%0t regCtrl expected %h actual %h instr %h", $time, exp, act, instr);
		abortRun("register write control differs from the reference");
	end
endtask

task automatic checkMemCtrl(input decodePkg::memCtrlT act, input decodePkg::memCtrlT exp);
	if (act !== exp) begin
		$display("ERROR t=%0t memCtrl expected %b actual %b instr %h", $time, exp, act, instr);
		abortRun("memory strobes differ from the reference");
	end
endtask

task automatic checkAluCtrl(input decodePkg::aluCtrlT act, input decodePkg::aluCtrlT exp);
	if (act !== exp) begin
		$display("ERROR t=%0t aluCtrl expected %h actual %h instr %h", $time, exp, act, instr);
		abortRun("alu control differs from the reference");
	end
endtask

task automatic checkBranch(input decodePkg::branchCondT act, input decodePkg::branchCondT exp);
	if (act !== exp) begin
		$display("ERROR t=%0t branchCond expected %s actual %s instr %h", $time,
			exp.name(), act.name(), instr);
		abortRun("branch condition differs from the reference");
	end
endtask

task automatic checkPriv(input decodePkg::privCtrlT act, input decodePkg::privCtrlT exp);
	if (act !== exp) begin
		$display("ERROR t=%0t privCtrl expected %b actual %b instr %h", $time, exp, act, instr);
		abortRun("cp0 control differs from the reference");
	end
endtask

task automatic checkReserved(input logic act, input logic exp);
	if (act !== exp) begin
		$display("ERROR t=%0t reservedInstr expected %b actual %b instr %h", $time,
			exp, act, instr);
		abortRun("reserved instruction flag differs from the reference");
	end
endtask

`endif

// File: test/mainDecoderTb.sv
`timescale 1ns/100ps

module mainDecoderTb;

	logic clk = 1'b0;
	logic rst;
	logic checkEn;
	int numVectors;
	logic [31:0] lcgState;
	decodePkg::instrFieldsT instr;
	decodePkg::instrFieldsT vectors[$];
	decodePkg::regCtrlT regCtrl;
	decodePkg::memCtrlT memCtrl;
	decodePkg::aluCtrlT aluCtrl;
	decodePkg::branchCondT branchCond;
	decodePkg::privCtrlT privCtrl;
	logic reservedInstr;

	mainDecoder uut (
		.instr(instr),
		.regCtrl(regCtrl),
		.memCtrl(memCtrl),
		.aluCtrl(aluCtrl),
		.branchCond(branchCond),
		.privCtrl(privCtrl),
		.reservedInstr(reservedInstr)
	);

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("CHECKS FAILED");
		$fatal(1, "simulation stopped");
	endtask

	`include "refDecode.svh"

	expectT expected;

	always #4 clk = ~clk;

	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// opcode and funct fixed with random fields between them
	task automatic addVector(input logic [5:0] op, input logic [5:0] funct);
		logic [31:0] r;
		r = nextRandom();
		vectors.push_back({op, r[25:6], funct});
	endtask

	task automatic addWithSel(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [5:0] funct);
		logic [31:0] r;
		r = nextRandom();
		vectors.push_back({op, rs, rt, r[15:6], funct});
	endtask

	task automatic buildVectors();
		logic [31:0] r;
		// every funct of r-type and special2 including the traps
		for (int pass = 0; pass < 4; pass++) begin
			for (int k = 0; k < 64; k++) begin
				addVector(decodePkg::opRType, k[5:0]);
				addVector(decodePkg::opSpecial2, k[5:0]);
				// every major opcode including cache, special3 and unknowns
				r = nextRandom();
				addVector(k[5:0], r[11:6]);
			end
		end
		// regimm selectors, cop0 selectors and all co functs (tlb, wait, eret)
		for (int pass = 0; pass < 2; pass++) begin
			for (int k = 0; k < 64; k++) begin
				r = nextRandom();
				addWithSel(decodePkg::opCop0, decodePkg::rsCo, r[20:16], k[5:0]);
				if (k < 32) begin
					addWithSel(decodePkg::opRegImm, r[25:21], k[4:0], r[10:5]);
					addWithSel(decodePkg::opCop0, k[4:0], r[20:16], r[10:5]);
				end
			end
		end
		for (int k = 0; k < 300; k++)
			vectors.push_back(nextRandom());
	endtask

	always @(posedge clk) begin
		if (!rst && checkEn) begin
			expected = refDecode(instr);
			checkRegCtrl(regCtrl, expected.regCtrl);
			checkMemCtrl(memCtrl, expected.memCtrl);
			checkAluCtrl(aluCtrl, expected.aluCtrl);
			checkBranch(branchCond, expected.branchCond);
			checkPriv(privCtrl, expected.privCtrl);
			checkReserved(reservedInstr, expected.reservedInstr);
		end
	end

	initial begin
		rst = 1'b1;
		checkEn = 1'b0;
		numVectors = 0;
		lcgState = 32'h2219_2502;
		instr = '0;
		buildVectors();
		numVectors = vectors.size();
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		for (int n = 0; n < numVectors; n++) begin
			instr = vectors[n];
			checkEn = 1'b1;
			@(negedge clk);
		end
		checkEn = 1'b0;
		$display("ALL CHECKS PASSED");
		$finish;
	end

	// reset, one cycle per vector and a 64 cycle margin
	initial begin
		wait (numVectors > 0);
		#((8 + numVectors + 64) * 8);
		abortRun("timeout: the vectors did not finish in the expected time");
	end

endmodule

// File: mainDecoder.f
+incdir+test
common/decodePkg.sv
mainDecoder/aluOpDecode.sv
mainDecoder/regWriteDecode.sv
mainDecoder/branchDecode.sv
mainDecoder/privDecode.sv
mainDecoder/mainDecoder.sv
test/mainDecoderTb.sv
